// ==== dv/wino_golden.txt ====
# W: 36 weights row-major, T: gap flag then 36 input elements row-major (row = beat)
# E: four output beats of four pixels, pixel 0 first; flag 1 = random idle cycles
# All ones, identity tiles
W 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
T 1 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 0001 0002 0004 0008 0002 0004 0008 0010 0004 0008 0010 0020 0008 0010 0020 0040
T 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 0001 0000 0001 0000 0000 0002 0000 0002 0004 0000 0004 0000 0000 0008 0000 0008
# Signed weight set
W 1A2B F3C1 0456 E7D2 2B9E 0064 7F10 C3A5 0E21 0025 D4F8 3366 5A5A 0B77 A0C3 1F02 6D1E 9E4B 21C9 FFD7 08F5 03E8 B6A0 4C3D E011 2F6C 7B90 5D03 FFF9 0A8E 3C4D 91E2 0F0F 6A71 C2B8 1357
T 1 0000 0000 0000 0000 0000 07FF 0000 0000 0000 012C 0000 0000 0000 0000 0000 0000 0000 0000 0000 3F6A 0000 0000 0000 0000 0000 0000 0000 0000 03E8 0000 0000 0000 0000 0000 0000 0000
E 0028 0092 001E 01C6 00A5 0019 0191 0000 0058 01B8 0000 04D8 056D 0000 0525 0000
# Large sums wrap in the slice
T 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1FFF 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 7CFC F9F8 F3F0 E7E0 F9F8 F3F0 E7E0 CFC1 F3F0 E7E0 CFC1 9F83 E7E0 CFC1 9F83 3F06
T 0 0000 0000 0000 0000 0000 07FF 0000 0000 0000 012C 0000 0000 0000 0000 0000 0000 0000 0000 0000 3F6A 0000 0000 0000 0000 0000 0000 0000 0000 03E8 0000 0000 0000 0000 0000 0000 0000
E 0028 0092 001E 01C6 00A5 0019 0191 0000 0058 01B8 0000 04D8 056D 0000 0525 0000
# Reload, used weights negated
W 0D17 4E22 F810 1C6B A3F4 FF9C 2270 95AC 3E0D FFDB 01B4 7C29 C8E3 1A06 6F71 0BD2 E45A 2D90 7731 0029 B15E 0C44 3A0F F6E8 04A9 D2C7 19F3 8E65 0007 5B1C E93A 0C8B 6610 A2F7 1D45 3FB0
T 1 0000 0000 0000 0000 0000 07FF 0000 0000 0000 012C 0000 0000 0000 0000 0000 0000 0000 0000 0000 3F6A 0000 0000 0000 0000 0000 0000 0000 0000 03E8 0000 0000 0000 0000 0000 0000 0000
E 0000 0000 0000 0000 0000 0000 0000 009E 0000 0000 00A7 0000 0000 002A 0000 04BA
W 1A2B F3C1 0456 E7D2 2B9E 0064 7F10 C3A5 0E21 0025 D4F8 3366 5A5A 0B77 A0C3 1F02 6D1E 9E4B 21C9 FFD7 08F5 03E8 B6A0 4C3D E011 2F6C 7B90 5D03 FFF9 0A8E 3C4D 91E2 0F0F 6A71 C2B8 1357
T 1 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1FFF 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 7CFC F9F8 F3F0 E7E0 F9F8 F3F0 E7E0 CFC1 F3F0 E7E0 CFC1 9F83 E7E0 CFC1 9F83 3F06

// ==== dv/wino_tb.sv ====
`timescale 1ns/1ps

module wino_tb;
	import wino_pkg::*;

	localparam int CLK_HALF     = 4;
	localparam int RST_CYCLES   = 8;
	localparam int TILE_TIMEOUT = 50;
	localparam int RUN_TIMEOUT  = 2000;
	localparam int OUT_LATENCY  = 9; // Sixth input beat to first output beat

	logic          clk;
	logic          i_rst_n;
	logic          i_wgt_wr;
	wino_wgt_wr_t  i_wgt;
	logic          i_valid;
	wino_in_row_t  i_row;
	logic          o_valid;
	wino_out_row_t o_row;

	int fd;
	int cyc;
	int tiles_sent;
	int tiles_checked;

	logic [8*200-1:0] line_buf;

	// Expected first beat cycle per tile, expected rows in beat order
	int            first_cyc_q [$];
	wino_out_row_t exp_q [$];

	// Beats seen on the output, with the cycle each was sampled in
	wino_out_row_t got_row_q [$];
	int            got_cyc_q [$];

	wino_output_tile #(
		.OUT_SHIFT(8)
	) DUT (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wgt_wr(i_wgt_wr),
		.i_wgt   (i_wgt),
		.i_valid (i_valid),
		.i_row   (i_row),
		.o_valid (o_valid),
		.o_row   (o_row)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	always @(posedge clk) begin
		if (o_valid === 1'b1) begin
			got_row_q.push_back(o_row);
			got_cyc_q.push_back(cyc);
		end
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_row(input wino_out_row_t expected, input wino_out_row_t actual,
		input int idx);
		if (actual !== expected) begin
			stop_on_error($sformatf("Error o_row[%0d] tile %0d: expected %h, got %h",
				idx, tiles_checked, expected, actual));
		end
	endtask

	task automatic check_cycle(input int expected, input int actual, input int idx);
		if (actual != expected) begin
			stop_on_error($sformatf("Error o_valid beat %0d tile %0d: expected cycle %h, got %h",
				idx, tiles_checked, expected, actual));
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic read_hex(output logic [31:0] value);
		int code;
		code = $fscanf(fd, "%h", value);
		if (code != 1) begin
			stop_on_error("Golden file ended in the middle of a record");
		end
	endtask

	task automatic load_weights();
		logic [31:0] value;
		for (int r = 0; r < WINO_IN_TAPS; r++) begin
			for (int c = 0; c < WINO_IN_TAPS; c++) begin
				read_hex(value);
				i_wgt_wr = 1'b1;
				i_wgt.row = 3'(r);
				i_wgt.col = 3'(c);
				i_wgt.value = value[WINO_WGT_W-1:0];
				next_cycle();
			end
		end
		i_wgt_wr = 1'b0;
	endtask

	task automatic send_tile(input logic with_gaps);
		logic [31:0]  value;
		wino_in_row_t rows [WINO_IN_TAPS];
		int           gap;
		for (int r = 0; r < WINO_IN_TAPS; r++) begin
			for (int j = 0; j < WINO_IN_TAPS; j++) begin
				read_hex(value);
				rows[r].e[j] = value[WINO_DATA_W-1:0];
			end
		end
		for (int r = 0; r < WINO_IN_TAPS; r++) begin
			if (with_gaps) begin
				gap = $urandom_range(3, 0);
				repeat (gap) next_cycle();
			end
			if (r == WINO_IN_TAPS - 1) begin
				first_cyc_q.push_back(cyc + OUT_LATENCY); // cyc here is the sampling edge
			end
			i_valid = 1'b1;
			i_row = rows[r];
			next_cycle();
			i_valid = 1'b0;
		end
		tiles_sent++;
	endtask

	task automatic read_expected();
		logic [31:0]   value;
		wino_out_row_t row;
		for (int r = 0; r < WINO_OUT_TAPS; r++) begin
			for (int n = 0; n < WINO_OUT_TAPS; n++) begin
				read_hex(value);
				row.px[n] = value[WINO_PIX_W-1:0];
			end
			exp_q.push_back(row);
		end
	endtask

	task automatic wait_for_beats(input int count);
		int waited;
		waited = 0;
		while (got_row_q.size() < count) begin
			if (waited == TILE_TIMEOUT) begin
				stop_on_error($sformatf("Tile %0d produced no complete output within %0d cycles",
					tiles_checked, TILE_TIMEOUT));
			end
			next_cycle();
			waited++;
		end
	endtask

	task automatic check_tile();
		int            first;
		int            at;
		wino_out_row_t got;
		if (exp_q.size() < WINO_OUT_TAPS) begin
			stop_on_error("Golden file gives no expected rows for a tile that was sent");
		end
		wait_for_beats(WINO_OUT_TAPS);
		first = first_cyc_q.pop_front();
		for (int r = 0; r < WINO_OUT_TAPS; r++) begin
			got = got_row_q.pop_front();
			at = got_cyc_q.pop_front();
			check_cycle(first + r, at, r);
			check_row(exp_q.pop_front(), got, r);
		end
		tiles_checked++;
	endtask

	task automatic drain_all();
		while (first_cyc_q.size() > 0) begin
			check_tile();
		end
	endtask

	initial begin : run_timeout
		int waited;
		waited = 0;
		while (waited < RUN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		stop_on_error($sformatf("Run did not finish within %0d cycles", RUN_TIMEOUT));
	end

	initial begin : main_flow
		logic [7:0]  kind;
		logic [31:0] flag;
		int          code;
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_wgt_wr = 1'b0;
		i_wgt = '0;
		i_valid = 1'b0;
		i_row = '0;
		cyc = 0;
		tiles_sent = 0;
		tiles_checked = 0;
		void'($urandom(32'ha117));

		fd = $fopen("dv/wino_golden.txt", "r");
		if (fd == 0) begin
			stop_on_error("Could not open dv/wino_golden.txt");
		end

		repeat (RST_CYCLES) @(posedge clk);
		#1;
		i_rst_n = 1'b1;

		// Nothing may come out before a tile goes in
		repeat (10) next_cycle();
		if (got_row_q.size() != 0) begin
			stop_on_error("o_valid went high after reset before any tile was sent");
		end

		code = $fscanf(fd, "%s", kind);
		while (code == 1) begin
			case (kind)
				"#": code = $fgets(line_buf, fd);
				"W": begin
					drain_all(); // Store must be quiet while a tile is in flight
					load_weights();
				end
				"T": begin
					read_hex(flag);
					send_tile(flag[0]);
				end
				"E": read_expected();
				default: stop_on_error($sformatf("Unknown record kind %c in golden file", kind));
			endcase
			code = $fscanf(fd, "%s", kind);
		end
		$fclose(fd);

		drain_all();
		repeat (20) next_cycle();
		if (got_row_q.size() != 0 || exp_q.size() != 0) begin
			stop_on_error($sformatf("Output beats and expected rows do not match up after %0d tiles",
				tiles_sent));
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// ==== hdl/wino_adder_tree.sv ====
`timescale 1ns/1ps

module wino_adder_tree (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  wino_pkg::wino_prod_row_t i_in,
	output wino_pkg::wino_acc_t      o_sum
);
	import wino_pkg::*;

	localparam int SUM_W = WINO_ACC_W + 3; // Three guard bits

	logic signed [SUM_W-1:0] pair_q [3];
	logic signed [SUM_W-1:0] part_q [2];
	logic signed [SUM_W-1:0] total_q;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 3; i++) begin
				pair_q[i] <= '0;
			end
			part_q[0] <= '0;
			part_q[1] <= '0;
			total_q <= '0;
		end else begin
			pair_q[0] <= i_in.e[0] + i_in.e[1];
			pair_q[1] <= i_in.e[2] + i_in.e[3];
			pair_q[2] <= i_in.e[4] + i_in.e[5];
			part_q[0] <= pair_q[0] + pair_q[1];
			part_q[1] <= pair_q[2]; // Odd pair just moves along
			total_q <= part_q[0] + part_q[1];
		end
	end

	// Result wraps to the accumulator width
	assign o_sum = total_q[WINO_ACC_W-1:0];

endmodule

// ==== hdl/wino_hadamard.sv ====
`timescale 1ns/1ps

module wino_hadamard (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_wgt_wr,
	input  wino_pkg::wino_wgt_wr_t   i_wgt,
	input  logic                     i_valid,
	input  wino_pkg::wino_in_row_t   i_row,
	output logic                     o_valid,
	output wino_pkg::wino_prod_row_t o_row
);
	import wino_pkg::*;

	localparam int PROD_W = WINO_DATA_W + WINO_WGT_W;

	// Transformed weights, indexed [row][col]
	wino_wgt_t wgt_mem [WINO_IN_TAPS][WINO_IN_TAPS];

	logic [2:0]               row_cnt;
	logic signed [PROD_W-1:0] prod [WINO_IN_TAPS];
	wino_prod_row_t           prod_row;

	always_ff @(posedge clk) begin
		if (i_wgt_wr) begin
			wgt_mem[i_wgt.row][i_wgt.col] <= i_wgt.value;
		end
	end

	// Tile row position, selects the weight row
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			row_cnt <= '0;
		end else if (i_valid) begin
			if (row_cnt == 3'(WINO_IN_TAPS - 1)) begin
				row_cnt <= '0;
			end else begin
				row_cnt <= row_cnt + 3'd1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < WINO_IN_TAPS; i++) begin
			prod[i] = $signed(i_row.e[i]) * $signed(wgt_mem[row_cnt][i]);
			prod_row.e[i] = wino_acc_t'(prod[i]); // Sign extend to accumulator width
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_row <= prod_row;
		end
	end

endmodule

// ==== hdl/wino_inverse_transform.sv ====
`timescale 1ns/1ps

// Computes At*M*A on one 6x6 product tile. The column pass reduces each
// product row to four values, the row pass works on the serialized columns
// of that result, so output beat k carries column k of At*M*A
module wino_inverse_transform #(
	parameter int OUT_SHIFT = 8
) (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_valid,
	input  wino_pkg::wino_prod_row_t i_row,
	output logic                     o_valid,
	output wino_pkg::wino_out_row_t  o_row
);
	import wino_pkg::*;

	logic [2:0] in_cnt;
	logic [2:0] col_vld_d;
	logic [1:0] col_last_d;

	wino_prod_row_t col_terms [WINO_OUT_TAPS];
	wino_acc_t      col_sum [WINO_OUT_TAPS];
	// Slot 0 of the column buffer is the tree output itself
	wino_acc_t      col_buf [1:WINO_IN_TAPS-1][WINO_OUT_TAPS];

	wino_ser_state_e state_q, state_d;
	logic [1:0]      ser_cnt;
	wino_prod_row_t  tr_buf [WINO_OUT_TAPS];
	wino_prod_row_t  ser_row;

	wino_prod_row_t row_terms [WINO_OUT_TAPS];
	wino_acc_t      row_sum [WINO_OUT_TAPS];
	logic [2:0]     row_vld_d;

	// Operands of At row k; doubling and quadrupling by shifts
	function automatic wino_prod_row_t at_terms(input wino_prod_row_t v, input int k);
		wino_prod_row_t t;
		t = '0;
		case (k)
			0: begin
				t.e[0] = v.e[0];
				t.e[1] = v.e[1];
				t.e[2] = v.e[2];
				t.e[3] = v.e[3];
				t.e[4] = v.e[4];
			end
			1: begin
				t.e[1] = v.e[1];
				t.e[2] = -v.e[2];
				t.e[3] = v.e[3] <<< 1;
				t.e[4] = -(v.e[4] <<< 1);
			end
			2: begin
				t.e[1] = v.e[1];
				t.e[2] = v.e[2];
				t.e[3] = v.e[3] <<< 2;
				t.e[4] = v.e[4] <<< 2;
			end
			default: begin
				t.e[1] = v.e[1];
				t.e[2] = -v.e[2];
				t.e[3] = v.e[3] <<< 3;
				t.e[4] = -(v.e[4] <<< 3);
				t.e[5] = v.e[5];
			end
		endcase
		return t;
	endfunction

	// Row tracking and column pass valid delay
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			in_cnt <= '0;
			col_vld_d <= '0;
			col_last_d <= '0;
		end else begin
			if (i_valid) begin
				in_cnt <= (in_cnt == 3'(WINO_IN_TAPS - 1)) ? '0 : in_cnt + 3'd1;
			end
			col_vld_d <= {col_vld_d[1:0], i_valid};
			col_last_d <= {col_last_d[0], i_valid && (in_cnt == 3'(WINO_IN_TAPS - 1))};
		end
	end

	always_comb begin
		for (int k = 0; k < WINO_OUT_TAPS; k++) begin
			col_terms[k] = at_terms(i_row, k);
			row_terms[k] = at_terms(ser_row, k);
		end
	end

	for (genvar k = 0; k < WINO_OUT_TAPS; k++) begin : g_tree
		wino_adder_tree u_col_tree (
			.clk    (clk),
			.i_rst_n(i_rst_n),
			.i_in   (col_terms[k]),
			.o_sum  (col_sum[k])
		);

		wino_adder_tree u_row_tree (
			.clk    (clk),
			.i_rst_n(i_rst_n),
			.i_in   (row_terms[k]),
			.o_sum  (row_sum[k])
		);
	end

	// Newest finished row in slot 1, oldest in slot 5
	always_ff @(posedge clk) begin
		if (col_vld_d[2]) begin
			for (int k = 0; k < WINO_OUT_TAPS; k++) begin
				col_buf[1][k] <= col_sum[k];
				for (int j = 2; j < WINO_IN_TAPS; j++) begin
					col_buf[j][k] <= col_buf[j-1][k];
				end
			end
		end
	end

	// SER_LOAD lines up with the sixth column result
	always_comb begin
		state_d = state_q;
		case (state_q)
			SER_IDLE: begin
				if (col_last_d[1]) begin
					state_d = SER_LOAD;
				end
			end
			SER_LOAD: state_d = SER_SHIFT;
			SER_SHIFT: begin
				if (ser_cnt == 2'd3) begin
					state_d = SER_IDLE;
				end
			end
			default: state_d = SER_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= SER_IDLE;
			ser_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == SER_SHIFT) begin
				ser_cnt <= ser_cnt + 2'd1;
			end else begin
				ser_cnt <= '0;
			end
		end
	end

	// Transpose on capture, tr_buf[k].e[i] is column k of tile row i
	always_ff @(posedge clk) begin
		if (state_q == SER_LOAD) begin
			for (int k = 0; k < WINO_OUT_TAPS; k++) begin
				tr_buf[k].e[WINO_IN_TAPS-1] <= col_sum[k];
				for (int i = 0; i < WINO_IN_TAPS - 1; i++) begin
					tr_buf[k].e[i] <= col_buf[WINO_IN_TAPS-1-i][k];
				end
			end
		end
	end

	assign ser_row = tr_buf[ser_cnt];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			row_vld_d <= '0;
			o_valid <= 1'b0;
		end else begin
			row_vld_d <= {row_vld_d[1:0], state_q == SER_SHIFT};
			o_valid <= row_vld_d[2];
		end
	end

	// ReLU, then keep WINO_PIX_W bits from OUT_SHIFT up
	always_ff @(posedge clk) begin
		if (row_vld_d[2]) begin
			for (int n = 0; n < WINO_OUT_TAPS; n++) begin
				if (row_sum[n][WINO_ACC_W-1]) begin
					o_row.px[n] <= '0;
				end else begin
					o_row.px[n] <= row_sum[n][OUT_SHIFT +: WINO_PIX_W];
				end
			end
		end
	end

endmodule

// ==== hdl/wino_output_tile.sv ====
`timescale 1ns/1ps

module wino_output_tile #(
	parameter int OUT_SHIFT = 8 // LSB kept by the output slice
) (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  logic                    i_wgt_wr,
	input  wino_pkg::wino_wgt_wr_t  i_wgt,
	input  logic                    i_valid,
	input  wino_pkg::wino_in_row_t  i_row,
	output logic                    o_valid,
	output wino_pkg::wino_out_row_t o_row
);
	import wino_pkg::*;

	// Hadamard products, one beat per input row
	logic           prod_valid;
	wino_prod_row_t prod_row;

	wino_hadamard u_hadamard (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_wgt_wr(i_wgt_wr),
		.i_wgt   (i_wgt),
		.i_valid (i_valid),
		.i_row   (i_row),
		.o_valid (prod_valid),
		.o_row   (prod_row)
	);

	wino_inverse_transform #(
		.OUT_SHIFT(OUT_SHIFT)
	) u_inverse (
		.clk    (clk),
		.i_rst_n(i_rst_n),
		.i_valid(prod_valid),
		.i_row  (prod_row),
		.o_valid(o_valid),
		.o_row  (o_row)
	);

endmodule

// ==== hdl/wino_pkg.sv ====
package wino_pkg;

	// Tile geometry
	localparam int WINO_IN_TAPS  = 6;
	localparam int WINO_OUT_TAPS = 4;

	// Datapath widths
	localparam int WINO_DATA_W = 14;
	localparam int WINO_WGT_W  = 16;
	localparam int WINO_ACC_W  = 30;
	localparam int WINO_PIX_W  = 16;

	typedef logic signed [WINO_DATA_W-1:0] wino_data_t;
	typedef logic signed [WINO_WGT_W-1:0]  wino_wgt_t;
	typedef logic signed [WINO_ACC_W-1:0]  wino_acc_t;
	typedef logic        [WINO_PIX_W-1:0]  wino_pix_t;

	// One transformed input row, element 0 in the low bits
	typedef struct packed {
		wino_data_t [WINO_IN_TAPS-1:0] e;
	} wino_in_row_t;

	// One Hadamard product row, also the operand set of an adder tree
	typedef struct packed {
		wino_acc_t [WINO_IN_TAPS-1:0] e;
	} wino_prod_row_t;

	// One output beat of four pixels
	typedef struct packed {
		wino_pix_t [WINO_OUT_TAPS-1:0] px;
	} wino_out_row_t;

	// Single weight store write
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
		wino_wgt_t  value;
	} wino_wgt_wr_t;

	// Transpose buffer serializer
	typedef enum logic [1:0] {
		SER_IDLE,
		SER_LOAD,
		SER_SHIFT
	} wino_ser_state_e;

endpackage

// ==== verilog.f ====
hdl/wino_pkg.sv
hdl/wino_adder_tree.sv
hdl/wino_hadamard.sv
hdl/wino_inverse_transform.sv
hdl/wino_output_tile.sv
dv/wino_tb.sv
